// ==== raster_consts.svh ====
// Rasterizer constants
// Widths, tile geometry, pipeline latency and scissor register map

`ifndef RASTER_CONSTS_SVH
`define RASTER_CONSTS_SVH

// Datapath widths
`define RASTER_DIM_BITS      11
`define RASTER_COEF_BITS     16
`define RASTER_EDGE_BITS     32
`define RASTER_PID_BITS      8

// 8x8 pixel tile, walked as 4x4 quads
`define RASTER_TILE_LOGSIZE  3

`define RASTER_EDGE_LATENCY  2

// Primitives in flight between input and walker
`define RASTER_PENDING_BITS  3

// Scissor register map
`define RASTER_DCR_ADDR_BITS 2
`define RASTER_DCR_XMIN      2'd0
`define RASTER_DCR_XMAX      2'd1
`define RASTER_DCR_YMIN      2'd2
`define RASTER_DCR_YMAX      2'd3

`endif

// ==== hdl/raster_pkg.sv ====
// Rasterizer package
// Shared vector types and the walker state encoding

`default_nettype none

`include "raster_consts.svh"

package raster_pkg;

    typedef logic [`RASTER_DIM_BITS-1:0] raster_dim_t;
    typedef logic signed [`RASTER_COEF_BITS-1:0] raster_coef_t;
    typedef logic signed [`RASTER_EDGE_BITS-1:0] raster_edge_t;
    typedef logic [`RASTER_PID_BITS-1:0] raster_pid_t;

    // Bit index is row * 2 + column
    typedef logic [3:0] raster_mask_t;

    typedef logic [`RASTER_DCR_ADDR_BITS-1:0] raster_dcr_addr_t;

    typedef enum logic {
        WALKER_IDLE,
        WALKER_WALK
    } walker_state_t;

endpackage

`default_nettype wire

// ==== hdl/raster_dcr.sv ====
// Scissor register block
// Holds the clip rectangle, written through a simple register port

`timescale 1ns/100ps
`default_nettype none

`include "raster_consts.svh"

module raster_dcr import raster_pkg::*; (
    input  wire              clk,
    input  wire              reset,

    input  wire              dcr_wr_valid,
    input  raster_dcr_addr_t dcr_wr_addr,
    input  raster_dim_t      dcr_wr_data,

    output raster_dim_t      xmin,
    output raster_dim_t      xmax,
    output raster_dim_t      ymin,
    output raster_dim_t      ymax
);

    always_ff @(posedge clk) begin
        if (reset) begin
            // Whole screen
            xmin <= '0;
            xmax <= '1;
            ymin <= '0;
            ymax <= '1;
        end else if (dcr_wr_valid) begin
            case (dcr_wr_addr)
                `RASTER_DCR_XMIN: xmin <= dcr_wr_data;
                `RASTER_DCR_XMAX: xmax <= dcr_wr_data;
                `RASTER_DCR_YMIN: ymin <= dcr_wr_data;
                `RASTER_DCR_YMAX: ymax <= dcr_wr_data;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/raster_edge_eval.sv ====
// Edge evaluator
// Two-stage pipeline computing a*x + b*y + c for three edges at the tile origin

`timescale 1ns/100ps
`default_nettype none

`include "raster_consts.svh"

module raster_edge_eval import raster_pkg::*; (
    input  wire          clk,
    input  wire          reset,

    input  wire          prim_valid,
    output logic         prim_ready,
    input  raster_dim_t  prim_x,
    input  raster_dim_t  prim_y,
    input  raster_pid_t  prim_pid,
    input  wire          prim_last,
    input  raster_coef_t edge0_a,
    input  raster_coef_t edge0_b,
    input  raster_coef_t edge0_c,
    input  raster_coef_t edge1_a,
    input  raster_coef_t edge1_b,
    input  raster_coef_t edge1_c,
    input  raster_coef_t edge2_a,
    input  raster_coef_t edge2_b,
    input  raster_coef_t edge2_c,

    output logic         eval_valid,
    output raster_dim_t  eval_x,
    output raster_dim_t  eval_y,
    output raster_pid_t  eval_pid,
    output logic         eval_last,
    output raster_edge_t eval_e0,
    output raster_edge_t eval_e1,
    output raster_edge_t eval_e2,
    output raster_coef_t eval_a0,
    output raster_coef_t eval_b0,
    output raster_coef_t eval_a1,
    output raster_coef_t eval_b1,
    output raster_coef_t eval_a2,
    output raster_coef_t eval_b2,
    input  wire          walker_ready
);

    raster_coef_t a_in [3];
    raster_coef_t b_in [3];
    raster_coef_t c_in [3];

    logic [`RASTER_EDGE_LATENCY-1:0] valid_sr;
    logic stall;

    // Stage one
    raster_edge_t s1_ax [3];
    raster_edge_t s1_by [3];
    raster_coef_t s1_c [3];
    raster_coef_t s1_a [3];
    raster_coef_t s1_b [3];
    raster_dim_t  s1_x;
    raster_dim_t  s1_y;
    raster_pid_t  s1_pid;
    logic         s1_last;

    // Stage two
    raster_edge_t e_q [3];
    raster_coef_t a_q [3];
    raster_coef_t b_q [3];

    assign a_in = '{edge0_a, edge1_a, edge2_a};
    assign b_in = '{edge0_b, edge1_b, edge2_b};
    assign c_in = '{edge0_c, edge1_c, edge2_c};

    // Whole pipeline holds while the walker refuses its output
    assign stall      = eval_valid && !walker_ready;
    assign prim_ready = !stall;
    assign eval_valid = valid_sr[`RASTER_EDGE_LATENCY-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= '0;
        end else if (!stall) begin
            valid_sr <= {valid_sr[`RASTER_EDGE_LATENCY-2:0], prim_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int i = 0; i < 3; i++) begin
                s1_ax[i] <= raster_edge_t'(a_in[i]) * raster_edge_t'(prim_x);
                s1_by[i] <= raster_edge_t'(b_in[i]) * raster_edge_t'(prim_y);
                s1_c[i]  <= c_in[i];
                s1_a[i]  <= a_in[i];
                s1_b[i]  <= b_in[i];

                e_q[i] <= s1_ax[i] + s1_by[i] + raster_edge_t'(s1_c[i]);
                a_q[i] <= s1_a[i];
                b_q[i] <= s1_b[i];
            end
            s1_x    <= prim_x;
            s1_y    <= prim_y;
            s1_pid  <= prim_pid;
            s1_last <= prim_last;

            eval_x    <= s1_x;
            eval_y    <= s1_y;
            eval_pid  <= s1_pid;
            eval_last <= s1_last;
        end
    end

    assign eval_e0 = e_q[0];
    assign eval_e1 = e_q[1];
    assign eval_e2 = e_q[2];
    assign eval_a0 = a_q[0];
    assign eval_b0 = b_q[0];
    assign eval_a1 = a_q[1];
    assign eval_b1 = b_q[1];
    assign eval_a2 = a_q[2];
    assign eval_b2 = b_q[2];

endmodule

`default_nettype wire

// ==== hdl/raster_quad_walker.sv ====
// Quad walker
// Steps the 2x2 quads of one tile, forms scissored coverage masks
// and emits the non-empty quads

`timescale 1ns/100ps
`default_nettype none

`include "raster_consts.svh"

module raster_quad_walker import raster_pkg::*; (
    input  wire          clk,
    input  wire          reset,

    input  wire          eval_valid,
    output logic         walker_ready,
    input  raster_dim_t  eval_x,
    input  raster_dim_t  eval_y,
    input  raster_pid_t  eval_pid,
    input  wire          eval_last,
    input  raster_edge_t eval_e0,
    input  raster_edge_t eval_e1,
    input  raster_edge_t eval_e2,
    input  raster_coef_t eval_a0,
    input  raster_coef_t eval_b0,
    input  raster_coef_t eval_a1,
    input  raster_coef_t eval_b1,
    input  raster_coef_t eval_a2,
    input  raster_coef_t eval_b2,

    input  raster_dim_t  xmin,
    input  raster_dim_t  xmax,
    input  raster_dim_t  ymin,
    input  raster_dim_t  ymax,

    output logic         quad_valid,
    input  wire          quad_ready,
    output raster_dim_t  quad_x,
    output raster_dim_t  quad_y,
    output raster_mask_t quad_mask,
    output raster_pid_t  quad_pid,
    output logic         quad_last,

    output logic         tile_done,
    output logic         tile_last
);

    walker_state_t state;

    raster_edge_t e_in [3];
    raster_coef_t a_in [3];
    raster_coef_t b_in [3];

    raster_dim_t  tile_x;
    raster_dim_t  tile_y;
    raster_pid_t  pid_q;
    logic         last_q;
    raster_coef_t a_q [3];
    raster_coef_t b_q [3];
    raster_edge_t row_e [3];
    raster_edge_t cur_e [3];
    logic [`RASTER_TILE_LOGSIZE-2:0] qx;
    logic [`RASTER_TILE_LOGSIZE-2:0] qy;

    raster_dim_t  cur_x;
    raster_dim_t  cur_y;
    logic [1:0]   col_in;
    logic [1:0]   row_in;
    raster_mask_t edge_mask;
    raster_mask_t mask;
    logic         step;
    logic         tile_end;

    assign e_in = '{eval_e0, eval_e1, eval_e2};
    assign a_in = '{eval_a0, eval_a1, eval_a2};
    assign b_in = '{eval_b0, eval_b1, eval_b2};

    assign walker_ready = (state == WALKER_IDLE);

    // Advance unless a quad is held and not taken
    assign step     = (state == WALKER_WALK) && (!quad_valid || quad_ready);
    assign tile_end = (&qx) && (&qy);

    assign cur_x = tile_x + raster_dim_t'({qx, 1'b0});
    assign cur_y = tile_y + raster_dim_t'({qy, 1'b0});

    // Pixel offsets within the quad are 0, a, b and a+b
    always_comb begin
        edge_mask = '1;
        for (int i = 0; i < 3; i++) begin
            if (cur_e[i] < 0)
                edge_mask[0] = 1'b0;
            if (cur_e[i] + raster_edge_t'(a_q[i]) < 0)
                edge_mask[1] = 1'b0;
            if (cur_e[i] + raster_edge_t'(b_q[i]) < 0)
                edge_mask[2] = 1'b0;
            if (cur_e[i] + raster_edge_t'(a_q[i]) + raster_edge_t'(b_q[i]) < 0)
                edge_mask[3] = 1'b0;
        end
    end

    // Scissor test per column and row, int keeps x+1 from wrapping
    assign col_in[0] = (cur_x >= xmin) && (cur_x < xmax);
    assign col_in[1] = (int'(cur_x) + 1 >= int'(xmin)) && (int'(cur_x) + 1 < int'(xmax));
    assign row_in[0] = (cur_y >= ymin) && (cur_y < ymax);
    assign row_in[1] = (int'(cur_y) + 1 >= int'(ymin)) && (int'(cur_y) + 1 < int'(ymax));

    assign mask = edge_mask & {row_in[1] & col_in[1], row_in[1] & col_in[0],
                               row_in[0] & col_in[1], row_in[0] & col_in[0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= WALKER_IDLE;
            quad_valid <= 1'b0;
            tile_done  <= 1'b0;
        end else begin
            tile_done <= 1'b0;
            if (quad_valid && quad_ready)
                quad_valid <= 1'b0;
            case (state)
                WALKER_IDLE: begin
                    if (eval_valid)
                        state <= WALKER_WALK;
                end
                WALKER_WALK: begin
                    if (step) begin
                        if (mask != '0)
                            quad_valid <= 1'b1;
                        if (tile_end) begin
                            state     <= WALKER_IDLE;
                            tile_done <= 1'b1;
                        end
                    end
                end
                default: state <= WALKER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (walker_ready && eval_valid) begin
            tile_x <= eval_x;
            tile_y <= eval_y;
            pid_q  <= eval_pid;
            last_q <= eval_last;
            a_q    <= a_in;
            b_q    <= b_in;
            row_e  <= e_in;
            cur_e  <= e_in;
            qx     <= '0;
            qy     <= '0;
        end else if (step) begin
            if (mask != '0) begin
                quad_x    <= cur_x;
                quad_y    <= cur_y;
                quad_mask <= mask;
                quad_pid  <= pid_q;
                quad_last <= last_q;
            end
            if (&qx) begin
                // Next row starts 2b below the current row start
                qx <= '0;
                qy <= qy + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    row_e[i] <= row_e[i] + (raster_edge_t'(b_q[i]) <<< 1);
                    cur_e[i] <= row_e[i] + (raster_edge_t'(b_q[i]) <<< 1);
                end
            end else begin
                qx <= qx + 1'b1;
                for (int i = 0; i < 3; i++)
                    cur_e[i] <= cur_e[i] + (raster_edge_t'(a_q[i]) <<< 1);
            end
            if (tile_end)
                tile_last <= last_q;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/raster_unit.sv ====
// Tile rasterizer top level
// Edge evaluation, quad walking with scissor and the end-of-batch done beat

`timescale 1ns/100ps
`default_nettype none

`include "raster_consts.svh"

module raster_unit import raster_pkg::*; (
    input  wire              clk,
    input  wire              reset,

    input  wire              prim_valid,
    output logic             prim_ready,
    input  raster_dim_t      prim_x,
    input  raster_dim_t      prim_y,
    input  raster_pid_t      prim_pid,
    input  wire              prim_last,
    input  raster_coef_t     edge0_a,
    input  raster_coef_t     edge0_b,
    input  raster_coef_t     edge0_c,
    input  raster_coef_t     edge1_a,
    input  raster_coef_t     edge1_b,
    input  raster_coef_t     edge1_c,
    input  raster_coef_t     edge2_a,
    input  raster_coef_t     edge2_b,
    input  raster_coef_t     edge2_c,

    input  wire              dcr_wr_valid,
    input  raster_dcr_addr_t dcr_wr_addr,
    input  raster_dim_t      dcr_wr_data,

    output logic             out_valid,
    input  wire              out_ready,
    output logic             out_done,
    output raster_dim_t      out_x,
    output raster_dim_t      out_y,
    output raster_mask_t     out_mask,
    output raster_pid_t      out_pid
);

    raster_dim_t  xmin, xmax, ymin, ymax;

    logic         eval_valid, eval_last, walker_ready;
    raster_dim_t  eval_x, eval_y;
    raster_pid_t  eval_pid;
    raster_edge_t eval_e0, eval_e1, eval_e2;
    raster_coef_t eval_a0, eval_b0, eval_a1, eval_b1, eval_a2, eval_b2;

    logic         quad_valid, quad_ready, quad_last;
    raster_dim_t  quad_x, quad_y;
    raster_mask_t quad_mask;
    raster_pid_t  quad_pid;
    logic         tile_done, tile_last;

    logic [`RASTER_PENDING_BITS-1:0] pending_cnt;
    logic last_done;
    logic done_req;
    logic prim_fire;
    logic last_quad_waiting;

    raster_dcr raster_dcr_i (
        .clk(clk), .reset(reset),
        .dcr_wr_valid(dcr_wr_valid), .dcr_wr_addr(dcr_wr_addr), .dcr_wr_data(dcr_wr_data),
        .xmin(xmin), .xmax(xmax), .ymin(ymin), .ymax(ymax)
    );

    raster_edge_eval raster_edge_eval_i (
        .clk(clk), .reset(reset),
        .prim_valid(prim_valid), .prim_ready(prim_ready),
        .prim_x(prim_x), .prim_y(prim_y), .prim_pid(prim_pid), .prim_last(prim_last),
        .edge0_a(edge0_a), .edge0_b(edge0_b), .edge0_c(edge0_c),
        .edge1_a(edge1_a), .edge1_b(edge1_b), .edge1_c(edge1_c),
        .edge2_a(edge2_a), .edge2_b(edge2_b), .edge2_c(edge2_c),
        .eval_valid(eval_valid), .eval_x(eval_x), .eval_y(eval_y),
        .eval_pid(eval_pid), .eval_last(eval_last),
        .eval_e0(eval_e0), .eval_e1(eval_e1), .eval_e2(eval_e2),
        .eval_a0(eval_a0), .eval_b0(eval_b0), .eval_a1(eval_a1),
        .eval_b1(eval_b1), .eval_a2(eval_a2), .eval_b2(eval_b2),
        .walker_ready(walker_ready)
    );

    raster_quad_walker raster_quad_walker_i (
        .clk(clk), .reset(reset),
        .eval_valid(eval_valid), .walker_ready(walker_ready),
        .eval_x(eval_x), .eval_y(eval_y), .eval_pid(eval_pid), .eval_last(eval_last),
        .eval_e0(eval_e0), .eval_e1(eval_e1), .eval_e2(eval_e2),
        .eval_a0(eval_a0), .eval_b0(eval_b0), .eval_a1(eval_a1),
        .eval_b1(eval_b1), .eval_a2(eval_a2), .eval_b2(eval_b2),
        .xmin(xmin), .xmax(xmax), .ymin(ymin), .ymax(ymax),
        .quad_valid(quad_valid), .quad_ready(quad_ready),
        .quad_x(quad_x), .quad_y(quad_y), .quad_mask(quad_mask),
        .quad_pid(quad_pid), .quad_last(quad_last),
        .tile_done(tile_done), .tile_last(tile_last)
    );

    assign prim_fire = prim_valid && prim_ready;

    // With nothing pending, a held quad can only be from the last tile
    assign last_quad_waiting = quad_valid && quad_last;

    // Primitives accepted but whose tile has not finished
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_cnt <= '0;
        end else if (prim_fire && !tile_done) begin
            pending_cnt <= pending_cnt + 1'b1;
        end else if (!prim_fire && tile_done) begin
            pending_cnt <= pending_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_done <= 1'b0;
            done_req  <= 1'b0;
        end else begin
            if (tile_done && tile_last) begin
                last_done <= 1'b1;
            end else if (last_done && pending_cnt == '0 && !last_quad_waiting) begin
                last_done <= 1'b0;
                done_req  <= 1'b1;
            end
            if (done_req && out_ready && !quad_valid)
                done_req <= 1'b0;
        end
    end

    // Walker quads win over the done beat
    assign quad_ready = out_ready;
    assign out_valid  = quad_valid || done_req;
    assign out_done   = done_req && !quad_valid;
    assign out_x      = quad_valid ? quad_x : '0;
    assign out_y      = quad_valid ? quad_y : '0;
    assign out_mask   = quad_valid ? quad_mask : '0;
    assign out_pid    = quad_valid ? quad_pid : '0;

endmodule

`default_nettype wire

// ==== bench/raster_unit_tb.sv ====
// Rasterizer testbench
// Directed tests checked against a pixel-level coverage model, with random output stalls

`timescale 1ns/100ps
`default_nettype none

`include "raster_consts.svh"

module raster_unit_tb import raster_pkg::*; ();

    localparam int CLK_PERIOD      = 20;
    localparam int QUADS_PER_SIDE  = 1 << (`RASTER_TILE_LOGSIZE - 1);
    localparam int NUM_PRIMS       = 12;
    localparam int WATCHDOG_CYCLES = NUM_PRIMS * 40 + 1000;

    logic             clk = 1'b0;
    logic             reset;
    logic             prim_valid;
    logic             prim_ready;
    raster_dim_t      prim_x;
    raster_dim_t      prim_y;
    raster_pid_t      prim_pid;
    logic             prim_last;
    raster_coef_t     edge0_a, edge0_b, edge0_c;
    raster_coef_t     edge1_a, edge1_b, edge1_c;
    raster_coef_t     edge2_a, edge2_b, edge2_c;
    logic             dcr_wr_valid;
    raster_dcr_addr_t dcr_wr_addr;
    raster_dim_t      dcr_wr_data;
    logic             out_valid;
    logic             out_ready = 1'b1;
    logic             out_done;
    raster_dim_t      out_x;
    raster_dim_t      out_y;
    raster_mask_t     out_mask;
    raster_pid_t      out_pid;

    integer seed = 32'h6596;

    // Current primitive edges and scissor as seen by the model
    int coef_a [3];
    int coef_b [3];
    int coef_c [3];
    int sc_xmin = 0;
    int sc_xmax = 2047;
    int sc_ymin = 0;
    int sc_ymax = 2047;

    int exp_x [$];
    int exp_y [$];
    int exp_mask [$];
    int exp_pid [$];

    int  next_pid = 1;
    int  done_count = 0;
    int  done_expect = 0;
    bit  stall_enable = 1'b0;

    raster_unit raster_unit_i (
        .clk(clk), .reset(reset),
        .prim_valid(prim_valid), .prim_ready(prim_ready),
        .prim_x(prim_x), .prim_y(prim_y), .prim_pid(prim_pid), .prim_last(prim_last),
        .edge0_a(edge0_a), .edge0_b(edge0_b), .edge0_c(edge0_c),
        .edge1_a(edge1_a), .edge1_b(edge1_b), .edge1_c(edge1_c),
        .edge2_a(edge2_a), .edge2_b(edge2_b), .edge2_c(edge2_c),
        .dcr_wr_valid(dcr_wr_valid), .dcr_wr_addr(dcr_wr_addr), .dcr_wr_data(dcr_wr_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_done(out_done),
        .out_x(out_x), .out_y(out_y), .out_mask(out_mask), .out_pid(out_pid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("Fail %s: expected %h, got %h", name, exp, got);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    function automatic bit pixel_covered(input int x, input int y);
        bit covered;
        covered = (x >= sc_xmin) && (x < sc_xmax) && (y >= sc_ymin) && (y < sc_ymax);
        for (int i = 0; i < 3; i++) begin
            if (coef_a[i] * x + coef_b[i] * y + coef_c[i] < 0)
                covered = 1'b0;
        end
        return covered;
    endfunction

    // Expected quads of one tile in row-major order, empty quads skipped
    task automatic model_tile(input int px, input int py, input int pid);
        int x;
        int y;
        raster_mask_t mask;
        for (int qy = 0; qy < QUADS_PER_SIDE; qy++) begin
            for (int qx = 0; qx < QUADS_PER_SIDE; qx++) begin
                x = px + 2 * qx;
                y = py + 2 * qy;
                mask[0] = pixel_covered(x, y);
                mask[1] = pixel_covered(x + 1, y);
                mask[2] = pixel_covered(x, y + 1);
                mask[3] = pixel_covered(x + 1, y + 1);
                if (mask != '0) begin
                    exp_x.push_back(x);
                    exp_y.push_back(y);
                    exp_mask.push_back(mask);
                    exp_pid.push_back(pid);
                end
            end
        end
    endtask

    // Called on a falling edge; returns on the falling edge after the transfer
    task automatic send_prim(input int px, input int py, input bit last);
        model_tile(px, py, next_pid);
        prim_valid = 1'b1;
        prim_x     = raster_dim_t'(px);
        prim_y     = raster_dim_t'(py);
        prim_pid   = raster_pid_t'(next_pid);
        prim_last  = last;
        edge0_a    = raster_coef_t'(coef_a[0]);
        edge0_b    = raster_coef_t'(coef_b[0]);
        edge0_c    = raster_coef_t'(coef_c[0]);
        edge1_a    = raster_coef_t'(coef_a[1]);
        edge1_b    = raster_coef_t'(coef_b[1]);
        edge1_c    = raster_coef_t'(coef_c[1]);
        edge2_a    = raster_coef_t'(coef_a[2]);
        edge2_b    = raster_coef_t'(coef_b[2]);
        edge2_c    = raster_coef_t'(coef_c[2]);
        while (!prim_ready)
            @(negedge clk);
        @(negedge clk);
        prim_valid = 1'b0;
        next_pid   = (next_pid + 1) & 8'hff;
    endtask

    task automatic write_reg(input int addr, input int value);
        dcr_wr_valid = 1'b1;
        dcr_wr_addr  = raster_dcr_addr_t'(addr);
        dcr_wr_data  = raster_dim_t'(value);
        @(negedge clk);
        dcr_wr_valid = 1'b0;
    endtask

    task automatic set_scissor(input int xmin, input int xmax, input int ymin, input int ymax);
        write_reg(`RASTER_DCR_XMIN, xmin);
        write_reg(`RASTER_DCR_XMAX, xmax);
        write_reg(`RASTER_DCR_YMIN, ymin);
        write_reg(`RASTER_DCR_YMAX, ymax);
        sc_xmin = xmin;
        sc_xmax = xmax;
        sc_ymin = ymin;
        sc_ymax = ymax;
    endtask

    task automatic set_full_edges();
        for (int i = 0; i < 3; i++) begin
            coef_a[i] = 0;
            coef_b[i] = 0;
            coef_c[i] = 1;
        end
    endtask

    // Idle after the done beat to catch a second done beat
    task automatic wait_for_done();
        done_expect++;
        while (done_count < done_expect)
            @(negedge clk);
        repeat (20) @(negedge clk);
        check_value("done_count", done_count, done_expect);
    endtask

    task automatic full_coverage();
        set_full_edges();
        send_prim(16, 8, 1'b1);
        wait_for_done();
    endtask

    task automatic half_plane_edges();
        set_full_edges();
        coef_a[0] = -1;
        coef_c[0] = 32 + 3;
        coef_b[1] = -1;
        coef_c[1] = 24 + 5;
        send_prim(32, 24, 1'b1);
        wait_for_done();
    endtask

    task automatic scissor_clip();
        set_scissor(19, 22, 9, 14);
        set_full_edges();
        send_prim(16, 8, 1'b1);
        wait_for_done();
        set_scissor(0, 2047, 0, 2047);
    endtask

    task automatic empty_primitive();
        set_full_edges();
        coef_c[1] = -1;
        send_prim(40, 16, 1'b1);
        wait_for_done();
    endtask

    task automatic backpressure_ordering();
        int px;
        int py;
        int cx;
        int cy;
        stall_enable = 1'b1;
        set_full_edges();
        for (int n = 0; n < 8; n++) begin
            px = ($random(seed) & 255) * 8;
            py = ($random(seed) & 255) * 8;
            // Two random half-planes through points inside the tile
            for (int i = 0; i < 2; i++) begin
                coef_a[i] = $random(seed) % 5;
                coef_b[i] = $random(seed) % 5;
                cx = px + ($random(seed) & 7);
                cy = py + ($random(seed) & 7);
                coef_c[i] = ($random(seed) & 3) - (coef_a[i] * cx + coef_b[i] * cy);
            end
            send_prim(px, py, n == 7);
        end
        wait_for_done();
        stall_enable = 1'b0;
    endtask

    // Output monitor that also drives out_ready
    always @(negedge clk) begin
        if (reset) begin
            out_ready = 1'b1;
        end else begin
            if (stall_enable)
                out_ready = ($random(seed) & 1) != 0;
            else
                out_ready = 1'b1;
            if (out_valid && out_ready) begin
                if (out_done) begin
                    check_true(exp_x.size() == 0, "Done beat arrived before all quads");
                    check_value("out_mask", out_mask, 0);
                    done_count++;
                end else begin
                    check_true(exp_x.size() != 0, "DUT produced a quad that was not expected");
                    check_value("out_x", out_x, exp_x.pop_front());
                    check_value("out_y", out_y, exp_y.pop_front());
                    check_value("out_mask", out_mask, exp_mask.pop_front());
                    check_value("out_pid", out_pid, exp_pid.pop_front());
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Regression failed");
        $fatal(1);
    end

    initial begin
        reset        = 1'b1;
        prim_valid   = 1'b0;
        prim_x       = '0;
        prim_y       = '0;
        prim_pid     = '0;
        prim_last    = 1'b0;
        edge0_a      = '0;
        edge0_b      = '0;
        edge0_c      = '0;
        edge1_a      = '0;
        edge1_b      = '0;
        edge1_c      = '0;
        edge2_a      = '0;
        edge2_b      = '0;
        edge2_c      = '0;
        dcr_wr_valid = 1'b0;
        dcr_wr_addr  = '0;
        dcr_wr_data  = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        check_true(prim_ready === 1'b1, "prim_ready is not high after reset");
        check_true(out_valid === 1'b0, "out_valid is not low after reset");

        full_coverage();
        half_plane_edges();
        scissor_clip();
        empty_primitive();
        backpressure_ordering();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== raster_unit.f ====
+incdir+.
hdl/raster_pkg.sv
hdl/raster_dcr.sv
hdl/raster_edge_eval.sv
hdl/raster_quad_walker.sv
hdl/raster_unit.sv
bench/raster_unit_tb.sv
